//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := rab_core_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sources.f
verilog/rab_axi_pkg.sv
verilog/rab_slice_pkg.sv
verilog/rab_burst_range.sv
verilog/rab_slice_table.sv
verilog/rab_port_ctrl.sv
verilog/rab_core.sv
test/rab_core_sva.sv
test/rab_core_tb.sv

//--- test/rab_core_sva.sv
// RAB core protocol assertions
module rab_core_sva (
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic port1_sent,
  input logic port2_sent,
  input logic port1_accept,
  input logic port1_drop,
  input logic port2_accept,
  input logic port2_drop,
  input logic int_miss,
  input logic int_prot,
  input logic int_multi
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  function void flag_fail(string what);
    $error("%s", what);
    fail_cnt++;
  endfunction

  a_p1_excl: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !(port1_accept && port1_drop))
    else flag_fail("port1 accept and drop high together");
  a_p2_excl: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !(port2_accept && port2_drop))
    else flag_fail("port2 accept and drop high together");
  // one request in flight
  a_one_channel: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    !((port1_accept || port1_drop) && (port2_accept || port2_drop)))
    else flag_fail("both channels served at once");
  a_irq_drop: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (int_miss || int_prot || int_multi) |-> (port1_drop || port2_drop))
    else flag_fail("interrupt without a drop");
  a_p1_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (port1_accept && !port1_sent) |=> port1_accept)
    else flag_fail("port1 accept fell before sent");
  a_p2_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (port2_accept && !port2_sent) |=> port2_accept)
    else flag_fail("port2 accept fell before sent");

endmodule

bind rab_core rab_core_sva u_sva (
  .Clk_CI       (Clk_CI),
  .Rst_RBI      (Rst_RBI),
  .port1_sent   (port1_sent),
  .port2_sent   (port2_sent),
  .port1_accept (port1_accept),
  .port1_drop   (port1_drop),
  .port2_accept (port2_accept),
  .port2_drop   (port2_drop),
  .int_miss     (int_miss),
  .int_prot     (int_prot),
  .int_multi    (int_multi)
);

//--- test/rab_core_tb.sv
// RAB core testbench
module rab_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import rab_axi_pkg::*;
  import rab_slice_pkg::*;

  localparam int WAIT_LIMIT = 20;  // cycles per wait

  typedef struct packed {
    logic       accept;
    logic [2:0] irq;   // miss, prot, multi
    phys_addr_t addr;
  } outcome_t;

  typedef struct packed {
    logic       is_cfg;
    cfg_write_t cfg;
    logic [1:0] valid;   // bit 0 channel 1, bit 1 channel 2
    axi_req_t   req1;
    axi_req_t   req2;
    logic       exp_p1;  // channel 1 expected to be served
    outcome_t   want;
  } entry_t;

  logic         Clk_CI;
  logic         Rst_RBI;
  axi_req_t     port1_req;
  axi_req_t     port2_req;
  logic         port1_valid;
  logic         port2_valid;
  logic         port1_sent;
  logic         port2_sent;
  logic         cfg_wen;
  cfg_write_t   cfg_wr;
  logic         port1_accept;
  logic         port1_drop;
  logic         port2_accept;
  logic         port2_drop;
  logic         int_miss;
  logic         int_prot;
  logic         int_multi;
  phys_addr_t   out_addr;

  entry_t       table_q[$];
  slice_entry_t shadow [N_SLICES];  // reference copy of the slices
  logic         prio_p1;
  int           err_cnt;
  int           timeout_cnt;
  int           sva_cnt;

  rab_core u_rab_core (.*);

  always #2 Clk_CI = ~Clk_CI;

  function automatic axi_req_t make_req(virt_addr_t addr, int len, int size, logic rw,
                                        logic [USER_WIDTH-1:0] ctrl);
    axi_req_t r;
    r.addr = addr;
    r.len  = 8'(len);
    r.size = 3'(size);
    r.rw   = rw;
    r.ctrl = ctrl;
    return r;
  endfunction

  task automatic add_cfg(int slice, logic [FIELD_WIDTH-1:0] field, logic [63:0] data);
    entry_t e;
    e          = '0;
    e.is_cfg   = 1'b1;
    e.cfg.addr = {SLICE_IDX_WIDTH'(slice), field};
    e.cfg.data = data;
    table_q.push_back(e);
  endtask

  task automatic add_req(logic [1:0] valid, axi_req_t req1, axi_req_t req2, logic exp_p1,
                         logic accept, logic [2:0] irq, phys_addr_t addr);
    entry_t e;
    e             = '0;
    e.valid       = valid;
    e.req1        = req1;
    e.req2        = req2;
    e.exp_p1      = exp_p1;
    e.want.accept = accept;
    e.want.irq    = irq;
    e.want.addr   = addr;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    axi_req_t a;
    axi_req_t b;
    // slice 0 read only, slice 1 read/write, slice 2 overlaps slice 1
    add_cfg(0, REG_ADDR_START, 64'h1000);
    add_cfg(0, REG_ADDR_END, 64'h1fff);
    add_cfg(0, REG_OFFSET, 64'h10_0000_0000);
    add_cfg(0, REG_FLAGS, 64'h3);
    add_cfg(1, REG_ADDR_START, 64'h4000);
    add_cfg(1, REG_ADDR_END, 64'h4fff);
    add_cfg(1, REG_OFFSET, 64'h2_0000_8000);
    add_cfg(1, REG_FLAGS, 64'h7);
    add_cfg(2, REG_ADDR_START, 64'h4800);
    add_cfg(2, REG_ADDR_END, 64'h5fff);
    add_cfg(2, REG_OFFSET, 64'h3_0000_0000);
    add_cfg(2, REG_FLAGS, 64'h7);
    a = make_req(32'h1000, 0, 0, 1'b0, 6'h00);  // both valid, channel 2 first
    b = make_req(32'h4000, 0, 2, 1'b1, 6'h00);
    add_req(2'b11, a, b, 1'b0, 1'b1, 3'b000, 40'h02_0000_8000);
    add_req(2'b11, a, b, 1'b1, 1'b1, 3'b000, 40'h10_0000_0000);
    a = make_req(32'h1010, 0, 0, 1'b0, 6'h00);
    b = make_req(32'h1000, 0, 2, 1'b1, 6'h00);  // write into read only slice
    add_req(2'b11, a, b, 1'b0, 1'b0, 3'b010, '0);
    add_req(2'b11, a, b, 1'b1, 1'b1, 3'b000, 40'h10_0000_0010);
    add_req(2'b01, make_req(32'h1234, 3, 2, 1'b0, 6'h00), b, 1'b1, 1'b1, 3'b000,
            40'h10_0000_0234);
    // aligned to 0x1ff8 so the beat still fits
    add_req(2'b01, make_req(32'h1ffa, 0, 3, 1'b0, 6'h00), b, 1'b1, 1'b1, 3'b000,
            40'h10_0000_0ffa);
    add_req(2'b01, make_req(32'h1ff9, 1, 3, 1'b0, 6'h00), b, 1'b1, 1'b0, 3'b100, '0);
    add_req(2'b01, make_req(32'h1100, 0, 2, 1'b1, 6'h00), b, 1'b1, 1'b0, 3'b010, '0);
    a = make_req(32'h4900, 0, 0, 1'b0, 6'h00);
    add_req(2'b01, a, b, 1'b1, 1'b0, 3'b001, '0);
    add_cfg(2, REG_FLAGS, 64'h0);
    add_req(2'b01, a, b, 1'b1, 1'b1, 3'b000, 40'h02_0000_8900);
    b = make_req(32'h9000_0000, 7, 3, 1'b0, 6'h3f);  // bypass, no slice covers it
    add_req(2'b10, a, b, 1'b0, 1'b1, 3'b000, 40'h00_9000_0000);
  endtask

  task automatic model_cfg(cfg_write_t w);
    int s;
    s = int'(w.addr[CFG_ADDR_WIDTH-1:FIELD_WIDTH]);
    case (w.addr[FIELD_WIDTH-1:0])
      REG_ADDR_START: shadow[s].addr_start = w.data[ADDR_VIRT_WIDTH-1:0];
      REG_ADDR_END:   shadow[s].addr_end   = w.data[ADDR_VIRT_WIDTH-1:0];
      REG_OFFSET:     shadow[s].offset     = w.data[ADDR_PHYS_WIDTH-1:0];
      default:
      begin
        shadow[s].flags.en    = w.data[0];
        shadow[s].flags.rd_ok = w.data[1];
        shadow[s].flags.wr_ok = w.data[2];
      end
    endcase
  endtask

  function automatic burst_range_t model_range(axi_req_t req);
    burst_range_t r;
    int unsigned  nclr;
    int unsigned  bytes;
    nclr       = (req.size >= 3'd1 && req.size <= 3'd3) ? int'(req.size) : 0;
    bytes      = (int'(req.len) + 1) << req.size;
    r.addr_min = req.addr;
    r.addr_max = ((req.addr >> nclr) << nclr) + virt_addr_t'(bytes) - 32'd1;
    r.rw       = req.rw;
    r.skip     = &req.ctrl;
    return r;
  endfunction

  function automatic outcome_t model_decide(burst_range_t r);
    outcome_t o;
    int       hits;
    int       idx;
    logic     ok;
    o    = '0;
    hits = 0;
    idx  = 0;
    for (int i = 0; i < N_SLICES; i++)
    begin
      if (shadow[i].flags.en && shadow[i].addr_start <= r.addr_min
          && r.addr_max <= shadow[i].addr_end)
      begin
        if (hits == 0)
          idx = i;  // first hitting slice
        hits++;
      end
    end
    ok = r.rw ? shadow[idx].flags.wr_ok : shadow[idx].flags.rd_ok;
    if (r.skip)
    begin
      o.accept = 1'b1;
      o.addr   = phys_addr_t'(r.addr_min);
    end
    else if (hits > 1)
      o.irq = 3'b001;
    else if (hits == 0)
      o.irq = 3'b100;
    else if (!ok)
      o.irq = 3'b010;
    else
    begin
      o.accept = 1'b1;
      o.addr   = shadow[idx].offset + phys_addr_t'(r.addr_min - shadow[idx].addr_start);
    end
    return o;
  endfunction

  task automatic check_addr(string name, phys_addr_t act, phys_addr_t exp);
    if (act !== exp)
    begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_decision(string name, logic act, logic exp);
    if (act !== exp)
    begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_irq(logic [2:0] act, logic [2:0] exp);
    if (act !== exp)
    begin
      $display("Mismatch at %0t: {int_miss,int_prot,int_multi} is %b, expected %b",
               $time, act, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_decision(output logic ok);
    ok = 1'b0;
    for (int i = 0; i < WAIT_LIMIT && !ok; i++)
    begin
      @(negedge Clk_CI);
      ok = port1_accept | port1_drop | port2_accept | port2_drop;
    end
    if (!ok)
      $display("timeout at %0t waiting for an accept or drop", $time);
  endtask

  task automatic wait_release(input logic p1, output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    for (int i = 0; i < WAIT_LIMIT && !ok; i++)
    begin
      @(negedge Clk_CI);
      n++;
      ok = p1 ? !port1_accept : !port2_accept;
    end
    if (!ok)
      $display("timeout at %0t waiting for accept to fall after sent", $time);
    else if (n != 1)
    begin
      // accept must drop right after the edge that sees sent
      $display("accept fell %0d cycles after sent at %0t instead of one", n, $time);
      err_cnt++;
    end
  endtask

  task automatic apply_request(entry_t e, output logic ok);
    outcome_t want;
    logic     sel_p1;
    int       delay;
    sel_p1 = (prio_p1 & e.valid[0]) | ~e.valid[1];
    want   = model_decide(model_range(sel_p1 ? e.req1 : e.req2));
    if (sel_p1 !== e.exp_p1 || want.accept !== e.want.accept || want.irq !== e.want.irq
        || (want.accept && want.addr !== e.want.addr))
    begin
      $display("reference model disagrees with the stimulus table at %0t", $time);
      err_cnt++;
    end
    port1_req   = e.req1;
    port2_req   = e.req2;
    port1_valid = e.valid[0];
    port2_valid = e.valid[1];
    wait_decision(ok);
    port1_valid = 1'b0;
    port2_valid = 1'b0;
    if (ok)
    begin
      prio_p1 = ~sel_p1;  // other channel next
      check_decision("port1_accept", port1_accept, want.accept & sel_p1);
      check_decision("port1_drop", port1_drop, ~want.accept & sel_p1);
      check_decision("port2_accept", port2_accept, want.accept & ~sel_p1);
      check_decision("port2_drop", port2_drop, ~want.accept & ~sel_p1);
      check_irq({int_miss, int_prot, int_multi}, want.irq);
      if (want.accept)
      begin
        check_addr("out_addr", out_addr, want.addr);
        delay = $urandom_range(3, 0);
        repeat (delay)
        begin
          @(negedge Clk_CI);
          check_decision(sel_p1 ? "port1_accept" : "port2_accept",
                         sel_p1 ? port1_accept : port2_accept, 1'b1);
          check_addr("out_addr", out_addr, want.addr);
        end
        port1_sent = sel_p1;
        port2_sent = ~sel_p1;
        wait_release(sel_p1, ok);
        port1_sent = 1'b0;
        port2_sent = 1'b0;
      end
      else
      begin
        // drop and its interrupt last one cycle
        @(negedge Clk_CI);
        check_decision(sel_p1 ? "port1_drop" : "port2_drop",
                       sel_p1 ? port1_drop : port2_drop, 1'b0);
        check_irq({int_miss, int_prot, int_multi}, 3'b000);
      end
    end
  endtask

  initial
  begin
    logic ok;
    void'($urandom(32'h3c8));
    Clk_CI      = 1'b0;
    Rst_RBI     = 1'b0;
    port1_req   = '0;
    port2_req   = '0;
    port1_valid = 1'b0;
    port2_valid = 1'b0;
    port1_sent  = 1'b0;
    port2_sent  = 1'b0;
    cfg_wen     = 1'b0;
    cfg_wr      = '0;
    prio_p1     = 1'b0;  // channel 2 first after reset
    err_cnt     = 0;
    timeout_cnt = 0;
    for (int i = 0; i < N_SLICES; i++)
      shadow[i] = '0;
    build_table();
    repeat (4) @(posedge Clk_CI);
    @(negedge Clk_CI);
    // outputs cleared while in reset
    check_decision("port1_accept", port1_accept, 1'b0);
    check_decision("port1_drop", port1_drop, 1'b0);
    check_decision("port2_accept", port2_accept, 1'b0);
    check_decision("port2_drop", port2_drop, 1'b0);
    check_irq({int_miss, int_prot, int_multi}, 3'b000);
    check_addr("out_addr", out_addr, '0);
    Rst_RBI = 1'b1;

    for (int i = 0; i < table_q.size() && timeout_cnt == 0; i++)
    begin
      @(negedge Clk_CI);
      if (table_q[i].is_cfg)
      begin
        cfg_wen = 1'b1;
        cfg_wr  = table_q[i].cfg;
        model_cfg(table_q[i].cfg);
        @(negedge Clk_CI);
        cfg_wen = 1'b0;
      end
      else
      begin
        apply_request(table_q[i], ok);
        if (!ok)
          timeout_cnt++;
      end
    end

    repeat (2) @(negedge Clk_CI);
    sva_cnt = u_rab_core.u_sva.fail_cnt;
    $display("errors: %0d, assertion failures: %0d, timeouts: %0d",
             err_cnt, sva_cnt, timeout_cnt);
    if (err_cnt == 0 && sva_cnt == 0 && timeout_cnt == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- verilog/rab_axi_pkg.sv
// Request side types
package rab_axi_pkg;

  localparam int ADDR_VIRT_WIDTH = 32;
  localparam int ADDR_PHYS_WIDTH = 40;
  localparam int USER_WIDTH      = 6;  // all ones marks a bypass request
  localparam int SIZE_LSB_WIDTH  = 3;  // 8-byte data path

  localparam int LEN_WIDTH         = 8;
  localparam int SIZE_WIDTH        = 3;
  // (255 + 1) << 7 still fits
  localparam int BURST_BYTES_WIDTH = 16;

  typedef logic [ADDR_VIRT_WIDTH-1:0] virt_addr_t;
  typedef logic [ADDR_PHYS_WIDTH-1:0] phys_addr_t;

  // one burst request as seen on a channel
  typedef struct packed {
    virt_addr_t            addr;
    logic [LEN_WIDTH-1:0]  len;   // beats minus one
    logic [SIZE_WIDTH-1:0] size;  // log2 bytes per beat
    logic                  rw;    // 1 = write
    logic [USER_WIDTH-1:0] ctrl;
  } axi_req_t;

  // byte range covered by a burst
  typedef struct packed {
    virt_addr_t addr_min;  // unaligned start
    virt_addr_t addr_max;  // last byte touched
    logic       rw;
    logic       skip;      // bypass translation
  } burst_range_t;

endpackage

//--- verilog/rab_burst_range.sv
// Burst byte range front end
module rab_burst_range (
  input  rab_axi_pkg::axi_req_t     req,
  output rab_axi_pkg::burst_range_t range
);

  import rab_axi_pkg::*;

  logic [BURST_BYTES_WIDTH-1:0] burst_bytes;
  logic [SIZE_LSB_WIDTH-1:0]    mask;
  virt_addr_t                   align_addr;

  always_comb
  begin
    burst_bytes = (BURST_BYTES_WIDTH'(req.len) + 1'b1) << req.size;

    // clear the byte lanes below the beat size
    case (req.size)
      3'd1:    mask = 3'b110;
      3'd2:    mask = 3'b100;
      3'd3:    mask = 3'b000;
      default: mask = 3'b111;  // byte beats or wider than the bus
    endcase

    align_addr = {req.addr[ADDR_VIRT_WIDTH-1:SIZE_LSB_WIDTH],
                  req.addr[SIZE_LSB_WIDTH-1:0] & mask};
  end

  always_comb
  begin
    range.addr_min = req.addr;
    range.addr_max = align_addr + virt_addr_t'(burst_bytes) - 1'b1;
    range.rw       = req.rw;
    range.skip     = (req.ctrl == '1);
  end

endmodule

//--- verilog/rab_core.sv
// Remapping address block core
module rab_core (
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  rab_axi_pkg::axi_req_t     port1_req,
  input  rab_axi_pkg::axi_req_t     port2_req,
  input  logic                      port1_valid,
  input  logic                      port2_valid,
  input  logic                      port1_sent,
  input  logic                      port2_sent,
  input  logic                      cfg_wen,
  input  rab_slice_pkg::cfg_write_t cfg_wr,
  output logic                      port1_accept,
  output logic                      port1_drop,
  output logic                      port2_accept,
  output logic                      port2_drop,
  output logic                      int_miss,
  output logic                      int_prot,
  output logic                      int_multi,
  output rab_axi_pkg::phys_addr_t   out_addr
);

  import rab_axi_pkg::*;
  import rab_slice_pkg::*;

  burst_range_t port1_range;
  burst_range_t port2_range;
  burst_range_t sel_range;  // range of the arbitrated channel
  lookup_t      result;

  rab_burst_range u_port1_range (
    .req   (port1_req),
    .range (port1_range)
  );

  rab_burst_range u_port2_range (
    .req   (port2_req),
    .range (port2_range)
  );

  rab_slice_table u_slice_table (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .cfg_wen   (cfg_wen),
    .cfg_wr    (cfg_wr),
    .sel_range (sel_range),
    .result    (result)
  );

  rab_port_ctrl u_port_ctrl (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .port1_valid  (port1_valid),
    .port2_valid  (port2_valid),
    .port1_sent   (port1_sent),
    .port2_sent   (port2_sent),
    .port1_range  (port1_range),
    .port2_range  (port2_range),
    .result       (result),
    .sel_range    (sel_range),
    .port1_accept (port1_accept),
    .port1_drop   (port1_drop),
    .port2_accept (port2_accept),
    .port2_drop   (port2_drop),
    .int_miss     (int_miss),
    .int_prot     (int_prot),
    .int_multi    (int_multi),
    .out_addr     (out_addr)
  );

endmodule

//--- verilog/rab_port_ctrl.sv
// Port arbitration and decision FSM
module rab_port_ctrl (
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  logic                      port1_valid,
  input  logic                      port2_valid,
  input  logic                      port1_sent,
  input  logic                      port2_sent,
  input  rab_axi_pkg::burst_range_t port1_range,
  input  rab_axi_pkg::burst_range_t port2_range,
  input  rab_slice_pkg::lookup_t    result,
  output rab_axi_pkg::burst_range_t sel_range,
  output logic                      port1_accept,
  output logic                      port1_drop,
  output logic                      port2_accept,
  output logic                      port2_drop,
  output logic                      int_miss,
  output logic                      int_prot,
  output logic                      int_multi,
  output rab_axi_pkg::phys_addr_t   out_addr
);

  import rab_axi_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCEPT,  // accept held until sent
    ST_DROP     // drop pulse
  } state_t;

  state_t     state_q;
  logic       prio_p1_q;    // channel 1 wins when both are valid
  logic       served_p1_q;  // request in flight came from channel 1

  logic       select_p1;
  logic       req_valid;
  logic       sent;

  logic       dec_accept;
  logic       dec_miss;
  logic       dec_prot;
  logic       dec_multi;
  phys_addr_t dec_addr;

  assign select_p1 = (prio_p1_q & port1_valid) | ~port2_valid;
  assign sel_range = select_p1 ? port1_range : port2_range;
  assign req_valid = port1_valid | port2_valid;
  assign sent      = served_p1_q ? port1_sent : port2_sent;

  // decision order: skip, multi, miss, prot, accept
  always_comb
  begin
    dec_accept = 1'b0;
    dec_miss   = 1'b0;
    dec_prot   = 1'b0;
    dec_multi  = 1'b0;
    dec_addr   = result.out_addr;

    if (sel_range.skip)
    begin
      dec_accept = 1'b1;
      dec_addr   = phys_addr_t'(sel_range.addr_min);  // untranslated
    end
    else if (result.multi)
      dec_multi = 1'b1;
    else if (!result.hit)
      dec_miss = 1'b1;
    else if (result.prot)
      dec_prot = 1'b1;
    else
      dec_accept = 1'b1;
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state_q      <= ST_IDLE;
      prio_p1_q    <= 1'b0;  // channel 2 goes first
      served_p1_q  <= 1'b0;
      port1_accept <= 1'b0;
      port2_accept <= 1'b0;
      port1_drop   <= 1'b0;
      port2_drop   <= 1'b0;
      int_miss     <= 1'b0;
      int_prot     <= 1'b0;
      int_multi    <= 1'b0;
      out_addr     <= '0;
    end
    else
    begin
      port1_drop <= 1'b0;
      port2_drop <= 1'b0;
      int_miss   <= 1'b0;
      int_prot   <= 1'b0;
      int_multi  <= 1'b0;

      case (state_q)
        ST_IDLE:
          if (req_valid)
          begin
            served_p1_q  <= select_p1;
            prio_p1_q    <= ~select_p1;  // other channel next time
            port1_accept <= dec_accept & select_p1;
            port2_accept <= dec_accept & ~select_p1;
            port1_drop   <= ~dec_accept & select_p1;
            port2_drop   <= ~dec_accept & ~select_p1;
            int_miss     <= dec_miss;
            int_prot     <= dec_prot;
            int_multi    <= dec_multi;
            if (dec_accept)
            begin
              out_addr <= dec_addr;
              state_q  <= ST_ACCEPT;
            end
            else
              state_q <= ST_DROP;
          end
        ST_ACCEPT:
          if (sent)
          begin
            port1_accept <= 1'b0;
            port2_accept <= 1'b0;
            state_q      <= ST_IDLE;
          end
        default:
          state_q <= ST_IDLE;  // drop pulse ends here
      endcase
    end
  end

endmodule

//--- verilog/rab_slice_pkg.sv
// Translation slice types
package rab_slice_pkg;

  localparam int N_SLICES       = 4;
  localparam int REGS_PER_SLICE = 4;
  localparam int CFG_ADDR_WIDTH = 4;
  localparam int CFG_DATA_WIDTH = 64;

  // register index is slice * 4 + field
  localparam int FIELD_WIDTH     = $clog2(REGS_PER_SLICE);
  localparam int SLICE_IDX_WIDTH = CFG_ADDR_WIDTH - FIELD_WIDTH;
  localparam int HIT_CNT_WIDTH   = $clog2(N_SLICES + 1);

  localparam logic [FIELD_WIDTH-1:0] REG_ADDR_START = 2'd0;
  localparam logic [FIELD_WIDTH-1:0] REG_ADDR_END   = 2'd1;
  localparam logic [FIELD_WIDTH-1:0] REG_OFFSET     = 2'd2;
  localparam logic [FIELD_WIDTH-1:0] REG_FLAGS      = 2'd3;

  // flags register bits 0, 1 and 2
  typedef struct packed {
    logic en;
    logic rd_ok;
    logic wr_ok;
  } slice_flags_t;

  typedef struct packed {
    rab_axi_pkg::virt_addr_t addr_start;
    rab_axi_pkg::virt_addr_t addr_end;    // inclusive
    rab_axi_pkg::phys_addr_t offset;      // physical base of the slice
    slice_flags_t            flags;
  } slice_entry_t;

  typedef struct packed {
    logic [CFG_ADDR_WIDTH-1:0] addr;
    logic [CFG_DATA_WIDTH-1:0] data;
  } cfg_write_t;

  typedef struct packed {
    rab_axi_pkg::phys_addr_t out_addr;
    logic                    hit;
    logic                    prot;
    logic                    multi;
  } lookup_t;

endpackage

//--- verilog/rab_slice_table.sv
// Translation slice table
module rab_slice_table (
  input  logic                      Clk_CI,
  input  logic                      Rst_RBI,
  input  logic                      cfg_wen,
  input  rab_slice_pkg::cfg_write_t cfg_wr,
  input  rab_axi_pkg::burst_range_t sel_range,
  output rab_slice_pkg::lookup_t    result
);

  import rab_axi_pkg::*;
  import rab_slice_pkg::*;

  slice_entry_t               slices [N_SLICES];

  logic [SLICE_IDX_WIDTH-1:0] slice_sel;
  logic [FIELD_WIDTH-1:0]     field_sel;

  logic [N_SLICES-1:0]        slice_hit;
  logic [HIT_CNT_WIDTH-1:0]   hit_cnt;
  logic [SLICE_IDX_WIDTH-1:0] hit_idx;
  virt_addr_t                 hit_delta;  // distance from slice start

  assign slice_sel = cfg_wr.addr[CFG_ADDR_WIDTH-1:FIELD_WIDTH];
  assign field_sel = cfg_wr.addr[FIELD_WIDTH-1:0];

  // one field per strobe
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      for (int i = 0; i < N_SLICES; i++)
      begin
        slices[i] <= '0;
      end
    end
    else if (cfg_wen)
    begin
      case (field_sel)
        REG_ADDR_START:
          slices[slice_sel].addr_start <= cfg_wr.data[ADDR_VIRT_WIDTH-1:0];
        REG_ADDR_END:
          slices[slice_sel].addr_end <= cfg_wr.data[ADDR_VIRT_WIDTH-1:0];
        REG_OFFSET:
          slices[slice_sel].offset <= cfg_wr.data[ADDR_PHYS_WIDTH-1:0];
        default:
        begin
          slices[slice_sel].flags.en    <= cfg_wr.data[0];
          slices[slice_sel].flags.rd_ok <= cfg_wr.data[1];
          slices[slice_sel].flags.wr_ok <= cfg_wr.data[2];
        end
      endcase
    end
  end

  // whole burst must sit inside the slice
  always_comb
  begin
    for (int i = 0; i < N_SLICES; i++)
    begin
      slice_hit[i] = slices[i].flags.en
                     && (slices[i].addr_start <= sel_range.addr_min)
                     && (sel_range.addr_max <= slices[i].addr_end);
    end
  end

  always_comb
  begin
    hit_cnt = '0;
    hit_idx = '0;
    // walk downwards so the lowest hitting slice is kept
    for (int i = N_SLICES - 1; i >= 0; i--)
    begin
      if (slice_hit[i])
      begin
        hit_cnt = hit_cnt + 1'b1;
        hit_idx = SLICE_IDX_WIDTH'(i);
      end
    end
  end

  always_comb
  begin
    hit_delta    = sel_range.addr_min - slices[hit_idx].addr_start;

    result.hit   = |slice_hit;
    result.multi = (hit_cnt > HIT_CNT_WIDTH'(1));

    // permission of the hitting slice for this direction
    if (sel_range.rw)
    begin
      result.prot = result.hit & ~slices[hit_idx].flags.wr_ok;
    end
    else
    begin
      result.prot = result.hit & ~slices[hit_idx].flags.rd_ok;
    end

    result.out_addr = slices[hit_idx].offset + phys_addr_t'(hit_delta);
  end

endmodule
